// ==== rtl/robot_config.svh ====
`ifndef ROBOT_CONFIG_SVH
`define ROBOT_CONFIG_SVH

// clock cycles per timer tick
`define TICK_CYCLES 16
// cycles a sensor pattern has to stay stable
`define FILTER_CYCLES 3

// phase lengths in ticks
`define COUNT_TICKS 3
`define PAUSE_TICKS 2
`define TIMER_W 4

// lamp rotation and back blink half-period
`define LAMP_CYCLES 32

// motor pwm, high cycles per period
`define PWM_PERIOD 16
`define DUTY_FULL 12
`define DUTY_SLOW 4

`endif

// ==== rtl/robotPkg.sv ====
package robotPkg;

    // sensor pattern, left mid right
    typedef enum logic [2:0] {
        ROAD_LOST     = 3'b000,
        ROAD_EDGE_R   = 3'b001,
        ROAD_STRAIGHT = 3'b010,
        ROAD_RIGHT    = 3'b011,
        ROAD_EDGE_L   = 3'b100,
        ROAD_FORK     = 3'b101,
        ROAD_LEFT     = 3'b110,
        ROAD_CROSS    = 3'b111
    } roadPattern_t;

    typedef enum logic [3:0] {
        IDLE, START, COUNT, STRAIGHT, CHOOSE, LEFT, RIGHT, BACK,
        NUDGE_LEFT, NUDGE_RIGHT, STOP, FAULT
    } navState_t;

    // 0 to 9 are numerals
    typedef logic [3:0] digitCode_t;

    localparam digitCode_t DIGIT_P     = 4'd10;
    localparam digitCode_t DIGIT_BLANK = 4'd11;
    localparam digitCode_t DIGIT_S     = 4'd12;
    localparam digitCode_t DIGIT_L     = 4'd13;
    localparam digitCode_t DIGIT_B     = 4'd14;
    localparam digitCode_t DIGIT_R     = 4'd15;
    localparam digitCode_t DIGIT_ZERO  = 4'd0;

endpackage

// ==== rtl/timerIf.sv ====
`timescale 1ns/1ps
`include "robot_config.svh"

interface timerIf;

    logic                req;
    logic                ack;
    // ticks counted so far in this phase
    logic [`TIMER_W-1:0] elapsed;
    logic                tickPulse;

    modport controller (output req, input ack);
    modport timer (input req, output ack, output elapsed, output tickPulse);
    modport monitor (input req, input ack, input elapsed, input tickPulse);

endinterface

// ==== rtl/lineSampler.sv ====
`timescale 1ns/1ps
`include "robot_config.svh"

module lineSampler import robotPkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         leftTrack,
    input  logic         midTrack,
    input  logic         rightTrack,
    output roadPattern_t road
);

    localparam int CNT_W = $clog2(`FILTER_CYCLES + 1);

    logic [2:0]       syncA;
    logic [2:0]       syncB;
    // last synchronized pattern and how long it has held
    logic [2:0]       cand;
    logic [CNT_W-1:0] stableCnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncA     <= 3'b000;
            syncB     <= 3'b000;
            cand      <= 3'b000;
            stableCnt <= '0;
            road      <= ROAD_LOST;
        end else begin
            syncA <= {leftTrack, midTrack, rightTrack};
            syncB <= syncA;
            if (syncB != cand) begin
                cand      <= syncB;
                stableCnt <= CNT_W'(1);
            end else if (stableCnt < CNT_W'(`FILTER_CYCLES - 1)) begin
                stableCnt <= stableCnt + 1'b1;
            end else begin
                road <= roadPattern_t'(cand);
            end
        end
    end

endmodule

// ==== rtl/phaseTimer.sv ====
`timescale 1ns/1ps
`include "robot_config.svh"

module phaseTimer #(
    parameter int lengthTicks = 3
) (
    input  logic  clk,
    input  logic  rst,
    timerIf.timer tmr
);

    localparam int PRESC_W = $clog2(`TICK_CYCLES);
    localparam logic [`TIMER_W-1:0] LEN = `TIMER_W'(lengthTicks);

    logic [PRESC_W-1:0] presc;
    logic               running;

    // counting only until the full length is reached
    assign running       = tmr.req && !tmr.ack && (tmr.elapsed != LEN);
    assign tmr.tickPulse = running && (presc == PRESC_W'(`TICK_CYCLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            presc       <= '0;
            tmr.elapsed <= '0;
            tmr.ack     <= 1'b0;
        end else if (!tmr.req) begin
            // req dropped, release ack and start over
            presc       <= '0;
            tmr.elapsed <= '0;
            tmr.ack     <= 1'b0;
        end else begin
            if (running) begin
                presc <= tmr.tickPulse ? '0 : presc + 1'b1;
            end
            if (tmr.tickPulse) begin
                tmr.elapsed <= tmr.elapsed + 1'b1;
            end
            if (tmr.elapsed == LEN) begin
                tmr.ack <= 1'b1;
            end
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(tmr.ack) |-> $past(tmr.req));

    elapsedBounded: assert property (@(posedge clk) disable iff (rst)
        tmr.elapsed <= LEN);

endmodule

// ==== rtl/navigationControl.sv ====
`timescale 1ns/1ps

module navigationControl import robotPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  roadPattern_t      road,
    output navState_t         state,
    output navState_t         memory,
    timerIf.controller        countTmr,
    timerIf.controller        pauseTmr
);

    navState_t  nextState;
    navState_t  nextMemory;
    logic       inFollow;
    // one mark per state group, set once a non-cross pattern was seen
    logic       followMark;
    logic       chooseMark;
    logic       leftMark;
    logic       rightMark;
    logic [1:0] rightCnt;
    logic       rightDone;

    assign inFollow = state inside {STRAIGHT, NUDGE_LEFT, NUDGE_RIGHT};

    always_comb begin
        nextState  = state;
        nextMemory = memory;
        case (state)
            IDLE: if (run) nextState = START;
            START: if (road == ROAD_STRAIGHT) nextState = COUNT;
            COUNT: if (countTmr.ack) nextState = STRAIGHT;
            STRAIGHT, NUDGE_LEFT, NUDGE_RIGHT: begin
                case (road)
                    ROAD_LOST: begin
                        nextState  = STOP;
                        nextMemory = BACK;
                    end
                    ROAD_EDGE_R: nextState = NUDGE_RIGHT;
                    ROAD_EDGE_L: nextState = NUDGE_LEFT;
                    ROAD_CROSS: nextState = followMark ? CHOOSE : STRAIGHT;
                    default: nextState = STRAIGHT;
                endcase
            end
            CHOOSE: begin
                if (road == ROAD_FORK) begin
                    nextState  = STOP;
                    nextMemory = LEFT;
                end else if (road == ROAD_CROSS && chooseMark) begin
                    nextState = STRAIGHT;
                end
            end
            LEFT: begin
                if (road == ROAD_FORK) begin
                    nextState  = STOP;
                    nextMemory = RIGHT;
                end else if (road == ROAD_CROSS && leftMark) begin
                    nextState  = STOP;
                    nextMemory = STRAIGHT;
                end
            end
            RIGHT: begin
                if (road == ROAD_FORK && rightDone) begin
                    nextState = FAULT;
                end else if (road == ROAD_CROSS && rightMark && rightDone) begin
                    nextState  = STOP;
                    nextMemory = STRAIGHT;
                end
            end
            BACK: begin
                if (road == ROAD_CROSS) begin
                    nextState  = STOP;
                    nextMemory = LEFT;
                end
            end
            STOP: if (pauseTmr.ack) nextState = memory;
            default: nextState = state;
        endcase
        if (!run) begin
            nextState  = IDLE;
            nextMemory = IDLE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            memory       <= IDLE;
            countTmr.req <= 1'b0;
            pauseTmr.req <= 1'b0;
        end else begin
            state  <= nextState;
            memory <= nextMemory;
            // a new request waits until the previous ack is gone
            countTmr.req <= (nextState == COUNT) && !countTmr.ack;
            pauseTmr.req <= (nextState == STOP) && !pauseTmr.ack;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            followMark <= 1'b0;
            chooseMark <= 1'b0;
            leftMark   <= 1'b0;
            rightMark  <= 1'b0;
        end else begin
            if ((inFollow && road != ROAD_CROSS) || (state == COUNT && countTmr.ack)) begin
                followMark <= 1'b1;
            end else if (!inFollow) begin
                followMark <= 1'b0;
            end
            chooseMark <= (state == CHOOSE) && (chooseMark || road != ROAD_CROSS);
            leftMark   <= (state == LEFT) && (leftMark || road != ROAD_CROSS);
            rightMark  <= (state == RIGHT) && (rightMark || road != ROAD_CROSS);
        end
    end

    // right turn is confirmed by three crossing samples in a row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rightCnt  <= 2'd0;
            rightDone <= 1'b0;
        end else if (state != RIGHT) begin
            rightCnt  <= 2'd0;
            rightDone <= 1'b0;
        end else if (road == ROAD_CROSS) begin
            if (rightCnt != 2'd3) rightCnt <= rightCnt + 2'd1;
            if (rightCnt >= 2'd2) rightDone <= 1'b1;
        end else begin
            rightCnt <= 2'd0;
        end
    end

    countReqAfterAckLow: assert property (@(posedge clk) disable iff (rst)
        $rose(countTmr.req) |-> !$past(countTmr.ack));

    pauseReqAfterAckLow: assert property (@(posedge clk) disable iff (rst)
        $rose(pauseTmr.req) |-> !$past(pauseTmr.ack));

endmodule

// ==== rtl/statusDisplay.sv ====
`timescale 1ns/1ps
`include "robot_config.svh"

module statusDisplay import robotPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  navState_t        state,
    input  navState_t        memory,
    input  roadPattern_t     road,
    timerIf.monitor          countMon,
    output logic [15:0]      led,
    output digitCode_t [3:0] digits
);

    localparam int LAMP_W = $clog2(`LAMP_CYCLES);

    logic [LAMP_W-1:0] lampCnt;
    logic              lampWrap;
    logic [2:0]        chooseLamp;
    logic              backBlink;
    logic [4:0]        stateLamp;
    logic [5:0]        bar;
    digitCode_t        memLetter;

    assign lampWrap = (lampCnt == LAMP_W'(`LAMP_CYCLES - 1));

    // one divider serves the choose rotation and the back blink
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lampCnt    <= '0;
            chooseLamp <= 3'b001;
            backBlink  <= 1'b0;
        end else begin
            lampCnt    <= (state == CHOOSE || state == BACK) ? lampCnt + 1'b1 : '0;
            if (state != CHOOSE) chooseLamp <= 3'b001;
            else if (lampWrap) chooseLamp <= {chooseLamp[1:0], chooseLamp[2]};
            if (state != BACK) backBlink <= 1'b0;
            else if (lampWrap) backBlink <= !backBlink;
        end
    end

    always_comb begin
        case (state)
            START: stateLamp = 5'b00001;
            COUNT: stateLamp = 5'b00010;
            STRAIGHT, NUDGE_LEFT, NUDGE_RIGHT: stateLamp = 5'b01000;
            CHOOSE: stateLamp = {chooseLamp, 2'b00};
            LEFT: stateLamp = 5'b10000;
            RIGHT: stateLamp = 5'b00100;
            STOP: stateLamp = 5'b11100;
            BACK: stateLamp = 5'b01010;
            FAULT: stateLamp = 5'b11111;
            default: stateLamp = 5'b00000;
        endcase
        case (state)
            COUNT, STOP: bar = 6'b111111;
            STRAIGHT: bar = 6'b001100;
            LEFT: bar = 6'b110000;
            RIGHT: bar = 6'b000011;
            BACK: bar = backBlink ? 6'b000000 : 6'b111111;
            default: bar = 6'b000000;
        endcase
    end

    assign led = {stateLamp, 1'b0, bar, 1'b0, road};

    always_comb begin
        case (memory)
            STRAIGHT: memLetter = DIGIT_S;
            LEFT: memLetter = DIGIT_L;
            RIGHT: memLetter = DIGIT_R;
            BACK: memLetter = DIGIT_B;
            default: memLetter = DIGIT_BLANK;
        endcase
        case (state)
            IDLE: digits = {DIGIT_S, DIGIT_BLANK, DIGIT_BLANK, DIGIT_BLANK};
            // remaining countdown ticks in the last digit
            COUNT: digits = {DIGIT_BLANK, DIGIT_BLANK, DIGIT_BLANK,
                             digitCode_t'(`COUNT_TICKS - countMon.elapsed)};
            STOP, BACK: digits = {DIGIT_P, DIGIT_ZERO, DIGIT_ZERO, memLetter};
            default: digits = {DIGIT_P, DIGIT_ZERO, DIGIT_ZERO, DIGIT_ZERO};
        endcase
    end

endmodule

// ==== rtl/motorDrive.sv ====
`timescale 1ns/1ps
`include "robot_config.svh"

module motorDrive import robotPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  navState_t  state,
    output logic [1:0] leftDir,
    output logic [1:0] rightDir,
    output logic       leftPwm,
    output logic       rightPwm
);

    localparam int PWM_W = $clog2(`PWM_PERIOD);
    localparam logic [1:0] FWD = 2'b10;
    localparam logic [1:0] REV = 2'b01;
    localparam logic [1:0] HALT = 2'b00;

    logic [PWM_W-1:0] pwmCnt;
    logic [1:0]       leftDirNext;
    logic [1:0]       rightDirNext;
    // one extra bit so a duty of a full period still fits
    logic [PWM_W:0]   leftDuty;
    logic [PWM_W:0]   rightDuty;

    always_comb begin
        leftDirNext  = HALT;
        rightDirNext = HALT;
        leftDuty     = '0;
        rightDuty    = '0;
        case (state)
            STRAIGHT, NUDGE_LEFT, NUDGE_RIGHT, CHOOSE, BACK: begin
                leftDirNext  = FWD;
                rightDirNext = FWD;
                leftDuty     = (state == NUDGE_LEFT) ? (PWM_W+1)'(`DUTY_SLOW)
                                                     : (PWM_W+1)'(`DUTY_FULL);
                rightDuty    = (state == NUDGE_RIGHT) ? (PWM_W+1)'(`DUTY_SLOW)
                                                      : (PWM_W+1)'(`DUTY_FULL);
            end
            LEFT: begin
                leftDirNext  = REV;
                rightDirNext = FWD;
                leftDuty     = (PWM_W+1)'(`DUTY_FULL);
                rightDuty    = (PWM_W+1)'(`DUTY_FULL);
            end
            RIGHT: begin
                leftDirNext  = FWD;
                rightDirNext = REV;
                leftDuty     = (PWM_W+1)'(`DUTY_FULL);
                rightDuty    = (PWM_W+1)'(`DUTY_FULL);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwmCnt   <= '0;
            leftDir  <= HALT;
            rightDir <= HALT;
            leftPwm  <= 1'b0;
            rightPwm <= 1'b0;
        end else begin
            pwmCnt   <= (pwmCnt == PWM_W'(`PWM_PERIOD - 1)) ? '0 : pwmCnt + 1'b1;
            leftDir  <= leftDirNext;
            rightDir <= rightDirNext;
            leftPwm  <= {1'b0, pwmCnt} < leftDuty;
            rightPwm <= {1'b0, pwmCnt} < rightDuty;
        end
    end

endmodule

// ==== rtl/lineRobotTop.sv ====
`timescale 1ns/1ps
`include "robot_config.svh"

module lineRobotTop import robotPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic        leftTrack,
    input  logic        midTrack,
    input  logic        rightTrack,
    output logic [15:0] led,
    output logic [15:0] digitCodes,
    output logic [1:0]  leftDir,
    output logic [1:0]  rightDir,
    output logic        leftPwm,
    output logic        rightPwm
);

    roadPattern_t     road;
    navState_t        state;
    navState_t        memory;
    digitCode_t [3:0] digits;

    timerIf countIf ();
    timerIf pauseIf ();

    lineSampler uSampler (.clk(clk), .rst(rst), .leftTrack(leftTrack),
        .midTrack(midTrack), .rightTrack(rightTrack), .road(road));

    navigationControl uNav (.clk(clk), .rst(rst), .run(run), .road(road),
        .state(state), .memory(memory), .countTmr(countIf.controller),
        .pauseTmr(pauseIf.controller));

    // countdown and stop pause share one timer design
    phaseTimer #(.lengthTicks(`COUNT_TICKS)) uCountTimer (.clk(clk), .rst(rst),
        .tmr(countIf.timer));
    phaseTimer #(.lengthTicks(`PAUSE_TICKS)) uPauseTimer (.clk(clk), .rst(rst),
        .tmr(pauseIf.timer));

    statusDisplay uDisplay (.clk(clk), .rst(rst), .state(state), .memory(memory),
        .road(road), .countMon(countIf.monitor), .led(led), .digits(digits));

    motorDrive uMotor (.clk(clk), .rst(rst), .state(state), .leftDir(leftDir),
        .rightDir(rightDir), .leftPwm(leftPwm), .rightPwm(rightPwm));

    // first digit lands in the top nibble
    assign digitCodes = digits;

endmodule

// ==== verif/tbLineRobot.sv ====
`timescale 1ns/1ps
`include "robot_config.svh"

module tbLineRobot import robotPkg::*;;

    localparam int CLK_PERIOD = 100;
    localparam int HOLD = `FILTER_CYCLES + 6;
    localparam int COUNT_LEN = `COUNT_TICKS * `TICK_CYCLES;
    localparam int PAUSE_LEN = `PAUSE_TICKS * `TICK_CYCLES;
    localparam int MOTOR_HOLD = 40;
    localparam int GLITCHES = 12;
    // all phases and holds of the sequence below, with some slack
    localparam int RUN_CYCLES = 8 + 8 * HOLD + GLITCHES * (2 + HOLD) + 2 * COUNT_LEN
        + 2 * PAUSE_LEN + 3 * MOTOR_HOLD + 8 * HOLD + 40;
    localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES;

    localparam logic [4:0] LAMP_IDLE = 5'b00000;
    localparam logic [4:0] LAMP_START = 5'b00001;
    localparam logic [4:0] LAMP_COUNT = 5'b00010;
    localparam logic [4:0] LAMP_FOLLOW = 5'b01000;
    localparam logic [4:0] LAMP_LEFT = 5'b10000;
    localparam logic [4:0] LAMP_RIGHT = 5'b00100;
    localparam logic [4:0] LAMP_STOP = 5'b11100;
    localparam logic [4:0] LAMP_BACK = 5'b01010;
    localparam logic [15:0] IDLE_DIGITS = {DIGIT_S, DIGIT_BLANK, DIGIT_BLANK, DIGIT_BLANK};
    localparam digitCode_t COUNT_DIGIT_MAX = digitCode_t'(`COUNT_TICKS);
    localparam logic [1:0] MODE_OTHER = 2'd0;
    localparam logic [1:0] MODE_STRAIGHT = 2'd1;
    localparam logic [1:0] MODE_NUDGE_L = 2'd2;

    logic        clk;
    logic        rst;
    logic        run;
    logic        leftTrack;
    logic        midTrack;
    logic        rightTrack;
    logic [15:0] led;
    logic [15:0] digitCodes;
    logic [1:0]  leftDir;
    logic [1:0]  rightDir;
    logic        leftPwm;
    logic        rightPwm;

    logic [4:0]  lamp;
    logic [5:0]  bar;
    logic [2:0]  pins;
    logic [4:0]  pauseTarget;
    logic [1:0]  driveMode;
    logic [1:0]  lastMode = MODE_OTHER;
    int          modeRun = 0;
    int          countLen = 0;
    logic [`PWM_PERIOD-1:0] leftHist = '0;
    logic [`PWM_PERIOD-1:0] rightHist = '0;
    integer      seed;

    lineRobotTop dut (.clk(clk), .rst(rst), .run(run), .leftTrack(leftTrack),
        .midTrack(midTrack), .rightTrack(rightTrack), .led(led), .digitCodes(digitCodes),
        .leftDir(leftDir), .rightDir(rightDir), .leftPwm(leftPwm), .rightPwm(rightPwm));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign lamp = led[15:11];
    assign bar  = led[9:4];
    assign pins = {leftTrack, midTrack, rightTrack};

    // lamp the robot should show once a pause with this memory letter ends
    function automatic logic [4:0] lampAfterPause(input digitCode_t letter);
        case (letter)
            DIGIT_S: return LAMP_FOLLOW;
            DIGIT_L: return LAMP_LEFT;
            DIGIT_R: return LAMP_RIGHT;
            DIGIT_B: return LAMP_BACK;
            default: return LAMP_IDLE;
        endcase
    endfunction

    assign pauseTarget = lampAfterPause(digitCodes[3:0]);

    // straight and nudge left are told apart by the bar and the road bits
    assign driveMode = (lamp == LAMP_FOLLOW && bar == 6'b001100) ? MODE_STRAIGHT
                     : (lamp == LAMP_FOLLOW && bar == 6'b000000 && led[2:0] == ROAD_EDGE_L)
                       ? MODE_NUDGE_L : MODE_OTHER;

    always @(posedge clk) begin
        countLen  <= (lamp == LAMP_COUNT) ? countLen + 1 : 0;
        leftHist  <= {leftHist[`PWM_PERIOD-2:0], leftPwm};
        rightHist <= {rightHist[`PWM_PERIOD-2:0], rightPwm};
        lastMode  <= driveMode;
        if (driveMode != lastMode) begin
            modeRun <= 0;
        end else if (modeRun < 1000) begin
            modeRun <= modeRun + 1;
        end
    end

    task automatic endInFailure();
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        endInFailure();
    endtask

    task automatic holdRoad(input roadPattern_t pattern, input int cycles);
        {leftTrack, midTrack, rightTrack} = pattern;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic waitForLamp(input logic [4:0] want, input int maxCycles, input string what);
        int waited;
        waited = 0;
        while (lamp != want && waited < maxCycles) begin
            @(negedge clk);
            waited++;
        end
        if (lamp != want) begin
            $display("timed out waiting for %s", what);
            endInFailure();
        end
    endtask

    idleDisplay: assert property (@(posedge clk) disable iff (rst)
        lamp == LAMP_IDLE |-> digitCodes == IDLE_DIGITS && led[10:3] == 8'h00)
        else reportMismatch("idle display wrong");

    runLowStops: assert property (@(posedge clk) disable iff (rst)
        (!run && !$past(run) && !$past(run, 2))
            |-> lamp == LAMP_IDLE && leftDir == 2'b00 && rightDir == 2'b00
                && !leftPwm && !rightPwm)
        else reportMismatch("robot not stopped with run low");

    // 2 sync stages plus the filter length
    roadFollowsPins: assert property (@(posedge clk) disable iff (rst)
        (pins == $past(pins, 1) && pins == $past(pins, 2) && pins == $past(pins, 3)
            && pins == $past(pins, 4) && pins == $past(pins, 5)) |-> led[2:0] == pins)
        else reportMismatch("road bits do not follow steady sensors");

    glitchFiltered: assert property (@(posedge clk) disable iff (rst)
        led[2:0] != $past(led[2:0]) |-> $past(pins, 3) == led[2:0]
            && $past(pins, 4) == led[2:0] && $past(pins, 5) == led[2:0])
        else reportMismatch("short sensor glitch reached the road bits");

    idleToStart: assert property (@(posedge clk) disable iff (rst)
        ($past(lamp) == LAMP_IDLE && lamp != LAMP_IDLE) |-> lamp == LAMP_START)
        else reportMismatch("idle did not lead to start");

    startToCount: assert property (@(posedge clk) disable iff (rst)
        ($past(lamp) == LAMP_START && lamp != LAMP_START && $past(run)) |-> lamp == LAMP_COUNT)
        else reportMismatch("start did not lead to countdown");

    countDigits: assert property (@(posedge clk) disable iff (rst)
        lamp == LAMP_COUNT |-> digitCodes[15:4] == {DIGIT_BLANK, DIGIT_BLANK, DIGIT_BLANK}
            && digitCodes[3:0] <= COUNT_DIGIT_MAX)
        else reportMismatch("countdown digits out of range");

    countDigitFalls: assert property (@(posedge clk) disable iff (rst)
        (lamp == LAMP_COUNT && $past(lamp) == LAMP_COUNT)
            |-> digitCodes[3:0] <= $past(digitCodes[3:0]))
        else reportMismatch("countdown digit increased");

    countLength: assert property (@(posedge clk) disable iff (rst)
        ($past(lamp) == LAMP_COUNT && lamp != LAMP_COUNT && $past(run))
            |-> lamp == LAMP_FOLLOW && countLen >= COUNT_LEN - 2 && countLen <= COUNT_LEN + 2)
        else reportMismatch("countdown length or next state wrong");

    lostToStop: assert property (@(posedge clk) disable iff (rst)
        ($past(lamp) == LAMP_FOLLOW && $past(led[2:0]) == ROAD_LOST && $past(run))
            |-> lamp == LAMP_STOP && digitCodes == {DIGIT_P, DIGIT_ZERO, DIGIT_ZERO, DIGIT_B})
        else reportMismatch("line loss did not stop with back memory");

    backCrossToStop: assert property (@(posedge clk) disable iff (rst)
        ($past(lamp) == LAMP_BACK && $past(led[2:0]) == ROAD_CROSS && $past(run))
            |-> lamp == LAMP_STOP && digitCodes == {DIGIT_P, DIGIT_ZERO, DIGIT_ZERO, DIGIT_L})
        else reportMismatch("crossing in back did not stop with left memory");

    pauseExit: assert property (@(posedge clk) disable iff (rst)
        ($past(lamp) == LAMP_STOP && lamp != LAMP_STOP && $past(run))
            |-> lamp == $past(pauseTarget))
        else reportMismatch("state after pause does not match memory");

    // motor outputs lag the state by one cycle
    followDirections: assert property (@(posedge clk) disable iff (rst)
        lastMode != MODE_OTHER |-> leftDir == 2'b10 && rightDir == 2'b10)
        else reportMismatch("wheels not forward while following");

    leftSpinDirections: assert property (@(posedge clk) disable iff (rst)
        $past(lamp) == LAMP_LEFT |-> leftDir == 2'b01 && rightDir == 2'b10)
        else reportMismatch("wheels wrong in left turn");

    straightDuty: assert property (@(posedge clk) disable iff (rst)
        (lastMode == MODE_STRAIGHT && modeRun >= 20)
            |-> $countones(leftHist) == `DUTY_FULL && $countones(rightHist) == `DUTY_FULL)
        else reportMismatch("pwm duty wrong in straight");

    nudgeLeftDuty: assert property (@(posedge clk) disable iff (rst)
        (lastMode == MODE_NUDGE_L && modeRun >= 20)
            |-> $countones(leftHist) == `DUTY_SLOW && $countones(rightHist) == `DUTY_FULL)
        else reportMismatch("pwm duty wrong in left nudge");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the test sequence finished");
        endInFailure();
    end

    initial begin
        int idx;
        int rnd;
        roadPattern_t glitch;
        seed = 21256;
        rst = 1'b1;
        run = 1'b0;
        leftTrack = 1'b0;
        midTrack = 1'b0;
        rightTrack = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        // every pattern through the filter, still idle
        for (idx = 0; idx < 8; idx++) begin
            holdRoad(roadPattern_t'(idx), HOLD);
        end
        holdRoad(ROAD_STRAIGHT, HOLD);
        for (idx = 0; idx < GLITCHES; idx++) begin
            rnd = $random(seed);
            glitch = roadPattern_t'(ROAD_STRAIGHT ^ (3'(rnd) | 3'b001));
            holdRoad(glitch, rnd[8] ? 2 : 1);
            holdRoad(ROAD_STRAIGHT, HOLD);
        end

        run = 1'b1;
        waitForLamp(LAMP_COUNT, 6, "countdown to begin");
        waitForLamp(LAMP_FOLLOW, COUNT_LEN + 10, "end of countdown");
        holdRoad(ROAD_STRAIGHT, MOTOR_HOLD);
        holdRoad(ROAD_EDGE_L, MOTOR_HOLD);
        holdRoad(ROAD_STRAIGHT, HOLD);

        // lose the line, back up, then turn left at the crossing
        holdRoad(ROAD_LOST, 1);
        waitForLamp(LAMP_STOP, HOLD, "stop after line loss");
        waitForLamp(LAMP_BACK, PAUSE_LEN + 10, "back after pause");
        holdRoad(ROAD_LOST, HOLD);
        holdRoad(ROAD_CROSS, 1);
        waitForLamp(LAMP_STOP, HOLD, "stop at crossing");
        waitForLamp(LAMP_LEFT, PAUSE_LEN + 10, "left turn after pause");
        holdRoad(ROAD_LEFT, HOLD);

        run = 1'b0;
        waitForLamp(LAMP_IDLE, 3, "idle after run dropped in turn");
        holdRoad(ROAD_LEFT, HOLD);
        run = 1'b1;
        waitForLamp(LAMP_START, 3, "start on second run");
        holdRoad(ROAD_STRAIGHT, 1);
        waitForLamp(LAMP_COUNT, HOLD, "second countdown");
        repeat (COUNT_LEN / 2) @(negedge clk);
        run = 1'b0;
        waitForLamp(LAMP_IDLE, 3, "idle after run dropped in countdown");
        repeat (HOLD) @(negedge clk);

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/robotPkg.sv
rtl/timerIf.sv
rtl/lineSampler.sv
rtl/phaseTimer.sv
rtl/navigationControl.sv
rtl/statusDisplay.sv
rtl/motorDrive.sv
rtl/lineRobotTop.sv
verif/tbLineRobot.sv

// ==== Makefile ====
SRCS := $(filter %.sv,$(shell cat files.f)) rtl/robot_config.svh

.PHONY: all run clean

all: obj_dir/VtbLineRobot

# rebuilt only when a source or the file list changes
obj_dir/VtbLineRobot: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tbLineRobot -f files.f

# exit status of the simulator gives pass or fail
run: obj_dir/VtbLineRobot
	./obj_dir/VtbLineRobot

clean:
	rm -rf obj_dir
